// ==== include/spk_params.svh ====
`ifndef SPK_PARAMS_SVH
`define SPK_PARAMS_SVH

// Tone timer tick length in clk cycles
`define SPK_TONE_PRESCALE 4

// Quarter of an SCL bit period, in clk cycles
`define SPK_I2C_DIV 4

// Half of one bit clock period, in clk cycles
`define SPK_BCLK_DIV 2

// Codec write address, R/W bit already zero
`define SPK_CODEC_ADDR 8'h34

// Words in the codec setup table
`define SPK_CFG_LEN 6

// Sample magnitude, the speaker level supplies the sign bit
`define SPK_LEVEL 15'h4000

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the speaker audio testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module spk_audio_tb -f spk_audio_top.f \
  -o spk_audio_sim > build.log 2>&1 &&
  ./obj_dir/spk_audio_sim > sim.log 2>&1 ||
  { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0

// ==== sim/spk_audio_tb.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module spk_audio_tb;

  // Clk cycles per I2S frame and for the whole codec setup
  localparam int FRAME_CYC = 64 * `SPK_BCLK_DIV;
  localparam int CFG_CYC   = `SPK_CFG_LEN * 3 * 9 * 4 * `SPK_I2C_DIV;
  localparam int RUN_CYC   = CFG_CYC + 140 * FRAME_CYC + 4000;

  logic       clk;
  logic       rst_i;
  logic [1:0] wb_adr_i;
  logic [7:0] wb_dat_i;
  logic [7:0] wb_dat_o;
  logic       wb_we_i;
  logic       wb_stb_i;
  logic       wb_cyc_i;
  logic       wb_ack_o;
  logic       i2c_scl_o;
  logic       i2c_sda_o;
  logic       i2c_sda_i;
  logic       aud_bclk_o;
  logic       aud_daclrck_o;
  logic       aud_dacdat_o;
  logic       spk_o;
  logic       cfg_done_o;
  logic       cfg_err_o;

  int          err_cnt = 0;
  int          word_cnt = 0;
  int          frame_cnt = 0;
  int          done_rises = 0;
  logic [31:0] rand_q = 32'h8fe2_d70f;
  logic        quiet = 1'b0;
  logic        tone_on = 1'b0;
  logic        have_rise = 1'b0;
  logic        seen_hi = 1'b0;
  logic        seen_lo = 1'b0;
  int          exp_period = 0;
  logic [7:0]  rx_bytes [$];

  spk_audio_top dut0 (.*);

  always #4 clk = ~clk;

  // Open drain bus where the slave pulls SDA low in the ack slot
  logic ack_pull = 1'b0;
  assign i2c_sda_i = i2c_sda_o & ~ack_pull;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Rising edge spacing of the speaker wave in clk cycles
  function automatic int tone_period(input int div);
    int half;
    half = div / 2;
    if (half < 1) half = 1;
    return 2 * half * `SPK_TONE_PRESCALE;
  endfunction

  task automatic bus_write(input logic [1:0] adr, input logic [7:0] dat);
    @(posedge clk);
    #1;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_we_i  = 1'b1;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    @(posedge clk);
    #1;
    wb_we_i  = 1'b0;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
  endtask

  // CTRL write with only one of stb and cyc raised
  task automatic write_without_ack(input logic stb, input logic cyc, input logic [7:0] dat);
    @(posedge clk);
    #1;
    wb_adr_i = 2'd0;
    wb_dat_i = dat;
    wb_we_i  = 1'b1;
    wb_stb_i = stb;
    wb_cyc_i = cyc;
    @(posedge clk);
    #1;
    wb_we_i  = 1'b0;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
  endtask

  task automatic bus_read_check(input logic [1:0] adr, input logic [7:0] exp);
    @(posedge clk);
    #1;
    wb_adr_i = adr;
    wb_we_i  = 1'b0;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    #4;
    a_readback: assert (wb_dat_o === exp) else begin
      err_cnt++;
      $display("error: wb_dat_o = %h, expected %h at address %h", wb_dat_o, exp, adr);
    end
    @(posedge clk);
    #1;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    int start;
    start = frame_cnt;
    while (frame_cnt < start + n) @(posedge clk);
  endtask

  // Bus and configuration rules
  a_ack: assert property (@(posedge clk) wb_ack_o == (wb_stb_i && wb_cyc_i)) else begin
    err_cnt++;
    $display("error: wb_ack_o = %h, expected %h", wb_ack_o, wb_stb_i && wb_cyc_i);
  end
  a_no_nack: assert property (@(posedge clk) disable iff (rst_i) !cfg_err_o) else begin
    err_cnt++;
    $display("error: cfg_err_o = %h, expected 0", cfg_err_o);
  end
  a_done_holds: assert property (@(posedge clk) disable iff (rst_i)
    cfg_done_o |=> cfg_done_o) else begin
    err_cnt++;
    $display("cfg_done_o dropped after it had risen");
  end
  a_silent: assert property (@(posedge clk) disable iff (rst_i) quiet |-> !spk_o) else begin
    err_cnt++;
    $display("error: spk_o = %h while speaker is off, expected 0", spk_o);
  end
  // Data only moves right after a bclk falling edge
  a_dat_edge: assert property (@(posedge clk) disable iff (rst_i)
    $changed(aud_dacdat_o) |-> !aud_bclk_o) else begin
    err_cnt++;
    $display("dacdat changed while bclk was high");
  end

  // I2C slave model sampling on the falling clk edge
  logic scl_d = 1'b1;
  logic sda_d = 1'b1;
  logic done_d = 1'b0;
  int   bit_n = 0;
  logic [7:0] rx_sr;
  always @(negedge clk) begin
    if (i2c_scl_o && scl_d && sda_d && !i2c_sda_i) begin
      bit_n = 0;
    end else if (i2c_scl_o && !scl_d && bit_n < 8) begin
      rx_sr = {rx_sr[6:0], i2c_sda_i};
      bit_n++;
      if (bit_n == 8) rx_bytes.push_back(rx_sr);
    end else if (!i2c_scl_o && scl_d) begin
      // Ack slot opens after the eighth bit and closes after the ninth
      if (bit_n == 8) begin
        ack_pull <= 1'b1;
        bit_n = 9;
      end else if (bit_n == 9) begin
        ack_pull <= 1'b0;
        bit_n = 0;
      end
    end
    scl_d = i2c_scl_o;
    sda_d = i2c_sda_i;
    if (cfg_done_o && !done_d) done_rises++;
    done_d = cfg_done_o;
  end

  // I2S receiver where words finish one slot after the frame clock moves
  logic        bclk_d = 1'b0;
  logic        lr_d = 1'b0;
  logic        framed = 1'b0;
  int          slot_n = 0;
  logic [15:0] i2s_sr;
  logic [15:0] left_w;
  always @(negedge clk) begin
    if (!rst_i && aud_bclk_o && !bclk_d) begin
      i2s_sr = {i2s_sr[14:0], aud_dacdat_o};
      slot_n++;
      if (aud_daclrck_o != lr_d) begin
        if (framed) begin
          a_frame_len: assert (slot_n == 17) else begin
            err_cnt++;
            $display("frame clock half lasted %0d bclk periods instead of 16", slot_n - 1);
          end
        end
        framed = 1'b1;
        slot_n = 1;
        word_cnt++;
        a_word_val: assert (i2s_sr == 16'h4000 || i2s_sr == 16'hC000) else begin
          err_cnt++;
          $display("error: i2s word = %h, expected 4000 or c000", i2s_sr);
        end
        if (quiet) begin
          a_quiet_word: assert (i2s_sr == 16'h4000) else begin
            err_cnt++;
            $display("error: i2s word = %h while silent, expected 4000", i2s_sr);
          end
        end
        if (!lr_d) begin
          left_w = i2s_sr;
        end else begin
          a_lr_match: assert (i2s_sr == left_w) else begin
            err_cnt++;
            $display("error: right word = %h, expected left %h", i2s_sr, left_w);
          end
          if (tone_on && i2s_sr == 16'hC000) seen_hi = 1'b1;
          if (tone_on && i2s_sr == 16'h4000) seen_lo = 1'b1;
          frame_cnt++;
        end
      end
      lr_d = aud_daclrck_o;
    end
    bclk_d = aud_bclk_o;
  end

  // Speaker period between rising edges
  int   cyc_n = 0;
  int   last_rise = 0;
  logic spk_d = 1'b0;
  always @(negedge clk) begin
    cyc_n++;
    if (spk_o && !spk_d) begin
      if (tone_on && have_rise) begin
        a_period: assert (cyc_n - last_rise == exp_period) else begin
          err_cnt++;
          $display("error: spk_o period = %h, expected %h", cyc_n - last_rise, exp_period);
        end
      end
      last_rise = cyc_n;
      have_rise = tone_on;
    end
    spk_d = spk_o;
  end

  initial begin
    clk = 1'b0;
    rst_i = 1'b1;
    wb_adr_i = 2'd0;
    wb_dat_i = 8'h00;
    wb_we_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_i = 1'b0;

    bus_read_check(2'd0, 8'h00);
    bus_read_check(2'd1, 8'h00);
    bus_read_check(2'd2, 8'h00);
    // Upper CTRL bits stay clear of gate and enable here
    for (int i = 0; i < 4; i++) begin
      rand_q = next_rand(rand_q);
      bus_write(2'd0, rand_q[31:24] & 8'hFC);
      bus_write(2'd1, rand_q[23:16]);
      bus_write(2'd2, rand_q[15:8]);
      bus_read_check(2'd0, rand_q[31:24] & 8'hFC);
      bus_read_check(2'd1, rand_q[23:16]);
      bus_read_check(2'd2, rand_q[15:8]);
    end

    // Strobe without cycle and cycle without strobe leave CTRL alone
    write_without_ack(1'b1, 1'b0, ~(rand_q[31:24] & 8'hFC));
    write_without_ack(1'b0, 1'b1, ~(rand_q[31:24] & 8'hFC));
    bus_read_check(2'd0, rand_q[31:24] & 8'hFC);

    // Enable without gate and then gate without enable
    for (int m = 1; m <= 2; m++) begin
      bus_write(2'd0, (m == 1) ? 8'h02 : 8'h01);
      wait_frames(2);
      quiet = 1'b1;
      wait_frames(6);
      quiet = 1'b0;
    end

    for (int t = 0; t < 2; t++) begin
      bus_write(2'd0, 8'h00);
      rand_q = next_rand(rand_q);
      bus_write(2'd1, rand_q[23:16]);
      bus_write(2'd2, 8'h00);
      exp_period = tone_period(int'(rand_q[23:16]));
      seen_hi = 1'b0;
      seen_lo = 1'b0;
      have_rise = 1'b0;
      tone_on = 1'b1;
      bus_write(2'd0, 8'h03);
      wait_frames(40);
      tone_on = 1'b0;
      a_both_levels: assert (seen_hi && seen_lo) else begin
        err_cnt++;
        $display("tone run did not produce both sample levels");
      end
    end

    wait (cfg_done_o);
    repeat (20) @(posedge clk);
    a_done_once: assert (done_rises == 1) else begin
      err_cnt++;
      $display("cfg_done_o rose %0d times instead of once", done_rises);
    end
    a_byte_cnt: assert (rx_bytes.size() == 3 * `SPK_CFG_LEN) else begin
      err_cnt++;
      $display("codec received %0d bytes instead of %0d", rx_bytes.size(), 3 * `SPK_CFG_LEN);
    end
    for (int w = 0; w < `SPK_CFG_LEN && 3 * w + 2 < rx_bytes.size(); w++) begin
      a_cfg_bytes: assert (rx_bytes[3*w] == `SPK_CODEC_ADDR &&
                           rx_bytes[3*w+1] == spk_pkg::cfg_table[w][15:8] &&
                           rx_bytes[3*w+2] == spk_pkg::cfg_table[w][7:0]) else begin
        err_cnt++;
        $display("error: i2c triple = %h %h %h, expected %h %h", rx_bytes[3*w],
                 rx_bytes[3*w+1], rx_bytes[3*w+2], `SPK_CODEC_ADDR, spk_pkg::cfg_table[w]);
      end
    end

    $display("bytes %0d, words %0d, frames %0d, errors %0d",
             rx_bytes.size(), word_cnt, frame_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog sized from setup time plus all test frames
  initial begin
    #(RUN_CYC * 8);
    $display("timeout, the run did not finish in time");
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== spk_audio_top.f ====
+incdir+include
src/spk_pkg.sv
src/spk_i2c_if.sv
src/spk_port_regs.sv
src/spk_tone_timer.sv
src/spk_i2c_master.sv
src/spk_codec_config.sv
src/spk_i2s_tx.sv
src/spk_audio_top.sv
sim/spk_audio_tb.sv

// ==== src/spk_audio_top.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module spk_audio_top (
  input  logic       clk,
  input  logic       rst_i,
  input  logic [1:0] wb_adr_i,
  input  logic [7:0] wb_dat_i,
  output logic [7:0] wb_dat_o,
  input  logic       wb_we_i,
  input  logic       wb_stb_i,
  input  logic       wb_cyc_i,
  output logic       wb_ack_o,
  output logic       i2c_scl_o,
  output logic       i2c_sda_o,
  input  logic       i2c_sda_i,
  output logic       aud_bclk_o,
  output logic       aud_daclrck_o,
  output logic       aud_dacdat_o,
  output logic       spk_o,
  output logic       cfg_done_o,
  output logic       cfg_err_o
);

  logic [15:0] div;
  logic        gate;
  logic        tone;
  logic        spk;
  logic [15:0] sample;

  spk_i2c_if i2c_bus ();

  // Speaker level picks the sign, fixed magnitude
  assign sample = {spk, `SPK_LEVEL};
  assign spk_o  = spk;

  spk_port_regs u_regs (
    .clk      (clk),
    .rst_i    (rst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_we_i  (wb_we_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_ack_o (wb_ack_o),
    .tone_i   (tone),
    .div_o    (div),
    .gate_o   (gate),
    .spk_o    (spk)
  );

  spk_tone_timer u_timer (
    .clk    (clk),
    .rst_i  (rst_i),
    .div_i  (div),
    .gate_i (gate),
    .tone_o (tone)
  );

  spk_i2c_master u_i2c (
    .clk   (clk),
    .rst_i (rst_i),
    .bus   (i2c_bus),
    .scl_o (i2c_scl_o),
    .sda_o (i2c_sda_o),
    .sda_i (i2c_sda_i)
  );

  spk_codec_config u_cfg (
    .clk    (clk),
    .rst_i  (rst_i),
    .bus    (i2c_bus),
    .done_o (cfg_done_o),
    .err_o  (cfg_err_o)
  );

  // Mono source, same word on both channels
  spk_i2s_tx u_i2s (
    .clk      (clk),
    .rst_i    (rst_i),
    .left_i   (sample),
    .right_i  (sample),
    .bclk_o   (aud_bclk_o),
    .lrck_o   (aud_daclrck_o),
    .dacdat_o (aud_dacdat_o)
  );

endmodule

// ==== src/spk_codec_config.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module spk_codec_config (
  input  logic   clk,
  input  logic   rst_i,
  spk_i2c_if.cfg bus,
  output logic   done_o,
  output logic   err_o
);

  localparam int WORD_W = (`SPK_CFG_LEN > 1) ? $clog2(`SPK_CFG_LEN) : 1;
  localparam logic [WORD_W-1:0] WORD_LAST = WORD_W'(`SPK_CFG_LEN - 1);

  spk_pkg::cfg_state_e state_q;
  logic [WORD_W-1:0]   word_q;
  logic [1:0]          byte_q;
  logic [15:0]         word_data;
  logic                err_q;

  assign word_data = spk_pkg::cfg_table[word_q];

  // Address, high byte, low byte with stop
  always_comb begin
    case (byte_q)
      2'd0: begin
        bus.cmd     = spk_pkg::START_WRITE;
        bus.tx_byte = `SPK_CODEC_ADDR;
      end
      2'd1: begin
        bus.cmd     = spk_pkg::WRITE;
        bus.tx_byte = word_data[15:8];
      end
      default: begin
        bus.cmd     = spk_pkg::WRITE_STOP;
        bus.tx_byte = word_data[7:0];
      end
    endcase
  end

  assign bus.valid = (state_q == spk_pkg::CFG_ISSUE) && !bus.busy;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= spk_pkg::CFG_IDLE;
      word_q  <= '0;
      byte_q  <= 2'd0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        // One idle cycle keeps valid low out of reset
        spk_pkg::CFG_IDLE: state_q <= spk_pkg::CFG_ISSUE;
        spk_pkg::CFG_ISSUE: begin
          if (!bus.busy) begin
            state_q <= spk_pkg::CFG_WAIT;
          end
        end
        spk_pkg::CFG_WAIT: begin
          if (!bus.busy) begin
            err_q <= err_q | bus.nack;
            if (byte_q == 2'd2) begin
              byte_q <= 2'd0;
              if (word_q == WORD_LAST) begin
                state_q <= spk_pkg::CFG_DONE;
              end else begin
                word_q  <= word_q + 1'b1;
                state_q <= spk_pkg::CFG_ISSUE;
              end
            end else begin
              byte_q  <= byte_q + 2'd1;
              state_q <= spk_pkg::CFG_ISSUE;
            end
          end
        end
        default: state_q <= spk_pkg::CFG_DONE;
      endcase
    end
  end

  assign done_o = (state_q == spk_pkg::CFG_DONE);
  assign err_o  = err_q;

  // Requests only into an idle master, which then reports busy
  a_valid_idle: assert property (@(posedge clk) disable iff (rst_i)
    bus.valid |-> !bus.busy ##1 bus.busy);

endmodule

// ==== src/spk_i2c_if.sv ====
`timescale 1ns/1ps

// Byte-level link from the setup sequencer to the I2C master
interface spk_i2c_if;

  spk_pkg::i2c_cmd_e cmd;
  // Byte to send; named tx_byte since byte is a keyword
  logic [7:0]        tx_byte;
  // Single cycle request, only while busy is low
  logic              valid;
  // High from the cycle after valid until the ack bit or stop is done
  logic              busy;
  // Sticky, read it once busy has dropped
  logic              nack;

  modport cfg (
    output cmd,
    output tx_byte,
    output valid,
    input  busy,
    input  nack
  );

  modport mst (
    input  cmd,
    input  tx_byte,
    input  valid,
    output busy,
    output nack
  );

endinterface

// ==== src/spk_i2c_master.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module spk_i2c_master (
  input  logic   clk,
  input  logic   rst_i,
  spk_i2c_if.mst bus,
  output logic   scl_o,
  output logic   sda_o,
  input  logic   sda_i
);

  localparam int QW = (`SPK_I2C_DIV > 1) ? $clog2(`SPK_I2C_DIV) : 1;
  localparam logic [QW-1:0] Q_LAST = QW'(`SPK_I2C_DIV - 1);

  spk_pkg::i2c_state_e state_q;
  logic [QW-1:0]       qcnt_q;
  logic [1:0]          phase_q;
  logic [2:0]          bit_q;
  logic [7:0]          shift_q;
  logic                stop_q;
  logic                held_q;
  logic                nack_q;
  logic                qtick;
  logic                bit_end;

  // Four quarters per bit, SCL high in the middle two
  assign qtick   = (qcnt_q == Q_LAST);
  assign bit_end = qtick && (phase_q == 2'd3);

  assign bus.busy = (state_q != spk_pkg::I2C_IDLE);
  assign bus.nack = nack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= spk_pkg::I2C_IDLE;
      qcnt_q  <= '0;
      phase_q <= 2'd0;
      bit_q   <= 3'd0;
      stop_q  <= 1'b0;
      held_q  <= 1'b0;
      nack_q  <= 1'b0;
    end else begin
      if (state_q == spk_pkg::I2C_IDLE) begin
        qcnt_q  <= '0;
        phase_q <= 2'd0;
      end else begin
        qcnt_q <= qtick ? '0 : qcnt_q + 1'b1;
        if (qtick) begin
          phase_q <= phase_q + 2'd1;
        end
      end
      case (state_q)
        spk_pkg::I2C_IDLE: begin
          if (bus.valid) begin
            stop_q <= (bus.cmd == spk_pkg::WRITE_STOP);
            held_q <= 1'b1;
            bit_q  <= 3'd0;
            if (bus.cmd == spk_pkg::START_WRITE) begin
              // New transfer, forget the old nack
              nack_q  <= 1'b0;
              state_q <= spk_pkg::I2C_START;
            end else begin
              state_q <= spk_pkg::I2C_DATA;
            end
          end
        end
        spk_pkg::I2C_START: begin
          if (bit_end) begin
            state_q <= spk_pkg::I2C_DATA;
          end
        end
        spk_pkg::I2C_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_q <= spk_pkg::I2C_ACK;
            end
          end
        end
        spk_pkg::I2C_ACK: begin
          // Sample mid-high, slave pulls low to acknowledge
          if (qtick && phase_q == 2'd1) begin
            nack_q <= nack_q | sda_i;
          end
          if (bit_end) begin
            state_q <= stop_q ? spk_pkg::I2C_STOP : spk_pkg::I2C_IDLE;
          end
        end
        spk_pkg::I2C_STOP: begin
          if (bit_end) begin
            held_q  <= 1'b0;
            state_q <= spk_pkg::I2C_IDLE;
          end
        end
        default: state_q <= spk_pkg::I2C_IDLE;
      endcase
    end
  end

  // Data byte, MSB first
  always_ff @(posedge clk) begin
    if (state_q == spk_pkg::I2C_IDLE && bus.valid) begin
      shift_q <= bus.tx_byte;
    end else if (state_q == spk_pkg::I2C_DATA && bit_end) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  always_comb begin
    scl_o = 1'b1;
    sda_o = 1'b1;
    case (state_q)
      // SCL stays low between bytes of one transfer
      spk_pkg::I2C_IDLE:  scl_o = ~held_q;
      spk_pkg::I2C_START: begin
        scl_o = (phase_q != 2'd3);
        sda_o = ~phase_q[1];
      end
      spk_pkg::I2C_DATA: begin
        scl_o = phase_q[0] ^ phase_q[1];
        sda_o = shift_q[7];
      end
      spk_pkg::I2C_ACK:   scl_o = phase_q[0] ^ phase_q[1];
      spk_pkg::I2C_STOP: begin
        scl_o = (phase_q != 2'd0);
        sda_o = phase_q[1];
      end
      default: scl_o = 1'b1;
    endcase
  end

  // SDA only moves under high SCL for start and stop
  a_sda_stable: assert property (@(posedge clk) disable iff (rst_i)
    scl_o && $past(scl_o) &&
    !(state_q inside {spk_pkg::I2C_START, spk_pkg::I2C_STOP}) |-> $stable(sda_o));

endmodule

// ==== src/spk_i2s_tx.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module spk_i2s_tx (
  input  logic        clk,
  input  logic        rst_i,
  input  logic [15:0] left_i,
  input  logic [15:0] right_i,
  output logic        bclk_o,
  output logic        lrck_o,
  output logic        dacdat_o
);

  localparam int BW = (`SPK_BCLK_DIV > 1) ? $clog2(`SPK_BCLK_DIV) : 1;
  localparam logic [BW-1:0] B_LAST = BW'(`SPK_BCLK_DIV - 1);

  logic [BW-1:0] div_q;
  logic          bclk_q;
  logic          fall;
  logic [4:0]    bit_q;
  logic [4:0]    bit_nx;
  logic          lrck_q;
  logic          dat_q;
  logic [15:0]   shift_q;
  logic [15:0]   right_q;

  // Everything advances on the bclk falling edge
  assign fall   = (div_q == B_LAST) && bclk_q;
  assign bit_nx = bit_q + 5'd1;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      div_q   <= '0;
      bclk_q  <= 1'b0;
      // First falling edge opens the left half
      bit_q   <= 5'd31;
      lrck_q  <= 1'b0;
      dat_q   <= 1'b0;
      shift_q <= 16'h0000;
    end else begin
      div_q <= (div_q == B_LAST) ? '0 : div_q + 1'b1;
      if (div_q == B_LAST) begin
        bclk_q <= ~bclk_q;
      end
      if (fall) begin
        bit_q  <= bit_nx;
        lrck_q <= bit_nx[4];
        // LSB of the previous half still shifts out on the first slot
        dat_q  <= shift_q[15];
        if (bit_nx == 5'd0) begin
          shift_q <= left_i;
        end else if (bit_nx == 5'd16) begin
          shift_q <= right_q;
        end else begin
          shift_q <= {shift_q[14:0], 1'b0};
        end
      end
    end
  end

  // Right word captured with the left so a frame carries one sample
  always_ff @(posedge clk) begin
    if (fall && bit_nx == 5'd0) begin
      right_q <= right_i;
    end
  end

  assign bclk_o   = bclk_q;
  assign lrck_o   = lrck_q;
  assign dacdat_o = dat_q;

endmodule

// ==== src/spk_pkg.sv ====
`include "spk_params.svh"

package spk_pkg;

  // Wishbone register map
  typedef enum logic [1:0] {
    CTRL   = 2'd0,
    DIV_LO = 2'd1,
    DIV_HI = 2'd2
  } reg_addr_e;

  // Byte commands toward the I2C master
  typedef enum logic [1:0] {
    START_WRITE = 2'd0,
    WRITE       = 2'd1,
    WRITE_STOP  = 2'd2
  } i2c_cmd_e;

  typedef enum logic [2:0] {
    I2C_IDLE,
    I2C_START,
    I2C_DATA,
    I2C_ACK,
    I2C_STOP
  } i2c_state_e;

  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_ISSUE,
    CFG_WAIT,
    CFG_DONE
  } cfg_state_e;

  // Codec setup words, 7-bit register number over 9 data bits
  localparam logic [15:0] cfg_table [`SPK_CFG_LEN] = '{
    16'h0A00,  // Digital path, DAC soft mute off
    16'h0579,  // Headphone volume, both channels
    16'h0812,  // Analog path, DAC selected
    16'h0E02,  // I2S format, 16 bit words
    16'h1000,  // Normal mode, default rate
    16'h1201   // Interface active
  };

endpackage

// ==== src/spk_port_regs.sv ====
`timescale 1ns/1ps

module spk_port_regs (
  input  logic        clk,
  input  logic        rst_i,
  input  logic [1:0]  wb_adr_i,
  input  logic [7:0]  wb_dat_i,
  output logic [7:0]  wb_dat_o,
  input  logic        wb_we_i,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  output logic        wb_ack_o,
  input  logic        tone_i,
  output logic [15:0] div_o,
  output logic        gate_o,
  output logic        spk_o
);

  spk_pkg::reg_addr_e sel;
  logic               wr_en;
  logic [7:0]         ctrl_q;
  logic [7:0]         div_lo_q;
  logic [7:0]         div_hi_q;
  logic               spk_q;

  // Zero wait state slave
  assign wb_ack_o = wb_stb_i & wb_cyc_i;
  assign wr_en    = wb_ack_o & wb_we_i;
  assign sel      = spk_pkg::reg_addr_e'(wb_adr_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ctrl_q   <= 8'h00;
      div_lo_q <= 8'h00;
      div_hi_q <= 8'h00;
    end else if (wr_en) begin
      case (sel)
        spk_pkg::CTRL:   ctrl_q   <= wb_dat_i;
        spk_pkg::DIV_LO: div_lo_q <= wb_dat_i;
        spk_pkg::DIV_HI: div_hi_q <= wb_dat_i;
        default:         ctrl_q   <= ctrl_q;
      endcase
    end
  end

  // Read mux, unmapped address reads zero
  always_comb begin
    case (sel)
      spk_pkg::CTRL:   wb_dat_o = ctrl_q;
      spk_pkg::DIV_LO: wb_dat_o = div_lo_q;
      spk_pkg::DIV_HI: wb_dat_o = div_hi_q;
      default:         wb_dat_o = 8'h00;
    endcase
  end

  // Speaker level, bit 1 of CTRL enables the speaker
  always_ff @(posedge clk) begin
    if (rst_i) begin
      spk_q <= 1'b0;
    end else begin
      spk_q <= tone_i & ctrl_q[1];
    end
  end

  assign div_o  = {div_hi_q, div_lo_q};
  assign gate_o = ctrl_q[0];
  assign spk_o  = spk_q;

  // Register contents only move after an acknowledged write
  a_write_acked: assert property (@(posedge clk) disable iff (rst_i)
    !$stable({ctrl_q, div_lo_q, div_hi_q}) |-> $past(wb_ack_o && wb_we_i));

endmodule

// ==== src/spk_tone_timer.sv ====
`timescale 1ns/1ps
`include "spk_params.svh"

module spk_tone_timer (
  input  logic        clk,
  input  logic        rst_i,
  input  logic [15:0] div_i,
  input  logic        gate_i,
  output logic        tone_o
);

  localparam int PRE_W = (`SPK_TONE_PRESCALE > 1) ? $clog2(`SPK_TONE_PRESCALE) : 1;
  localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`SPK_TONE_PRESCALE - 1);

  logic [PRE_W-1:0] pre_q;
  logic             tick;
  logic [14:0]      reload;
  logic [14:0]      cnt_q;
  logic             tone_q;

  assign tick = (pre_q == PRE_LAST);
  // Half the divisor per level, never below one tick
  assign reload = (div_i[15:1] == 15'd0) ? 15'd1 : div_i[15:1];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pre_q  <= '0;
      cnt_q  <= '0;
      tone_q <= 1'b0;
    end else if (!gate_i) begin
      // Gate low parks the channel, count reloaded
      pre_q  <= '0;
      cnt_q  <= reload;
      tone_q <= 1'b0;
    end else begin
      pre_q <= tick ? '0 : pre_q + 1'b1;
      if (tick) begin
        // Terminal count flips the output and picks up a new divisor
        if (cnt_q <= 15'd1) begin
          cnt_q  <= reload;
          tone_q <= ~tone_q;
        end else begin
          cnt_q <= cnt_q - 15'd1;
        end
      end
    end
  end

  assign tone_o = tone_q;

  // Output silent once the gate has been low for a full cycle
  a_gate_silent: assert property (@(posedge clk) disable iff (rst_i)
    !gate_i && $past(!gate_i) |-> !tone_o);

endmodule
